/* hw/rab_pkg.sv */
package rab_pkg;

  // ------------------------------------------------------------------------
  // Miss record reported by a slave port
  // ------------------------------------------------------------------------

  // Direction of the access that missed in the remapping table
  typedef enum logic {
    RAB_READ  = 1'b0,
    RAB_WRITE = 1'b1
  } rab_access_e;

  // One translation miss, 39 bits
  typedef struct packed {
    logic [31:0] addr;
    logic [5:0]  id;
    rab_access_e access;
  } rab_miss_t;

  // ------------------------------------------------------------------------
  // Log storage
  // ------------------------------------------------------------------------

  // Entry in the shared log, the record plus the port it came from
  typedef struct packed {
    rab_miss_t miss;
    logic      port;
  } rab_log_entry_t;

  // Port that currently wins a tie in the arbiter
  typedef enum logic {
    PRIO_PORT0 = 1'b0,
    PRIO_PORT1 = 1'b1
  } rab_arb_prio_e;

  // Two ports only, the port field of a log entry is a single bit
  localparam int RAB_N_PORTS = 2;

  // RAM word widths for the buffers and the log
  localparam int RAB_MISS_BITS  = $bits(rab_miss_t);
  localparam int RAB_ENTRY_BITS = $bits(rab_log_entry_t);

endpackage

/* hw/rab_ram.sv */
`timescale 1ns/100ps

module rab_ram
  #(
    parameter int ADDR_WIDTH = 4,
    parameter int DATA_WIDTH = 32
  )
  (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output logic [DATA_WIDTH-1:0] rdata
  );

  // Storage array, no reset on payload
  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // Write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read port, one cycle of latency
  // On a same-address collision the new word is forwarded,
  // so a FIFO head written into an empty buffer shows up at once
  always_ff @(posedge clk)
  begin
    if (we && (waddr == raddr))
    begin
      rdata <= wdata;
    end
    else
    begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* hw/axi_buffer_rab_bram.sv */
`timescale 1ns/100ps

module axi_buffer_rab_bram
  #(
    parameter int BUFFER_DEPTH     = 8,
    parameter int LOG_BUFFER_DEPTH = 3
  )
  (
    input  logic                clk,
    input  logic                rstn,

    // Upstream side, from the slave port
    input  rab_pkg::rab_miss_t  data_in,
    input  logic                valid_in,
    output logic                ready_out,

    // Downstream side, towards the arbiter
    output rab_pkg::rab_miss_t  data_out,
    output logic                valid_out,
    input  logic                ready_in,

    // Level flush, empties the buffer while high
    input  logic                flush_entries
  );

  import rab_pkg::*;

  // ------------------------------------------------------------------------
  // Pointers and fill level
  // ------------------------------------------------------------------------

  // Next slot to write
  logic [LOG_BUFFER_DEPTH-1:0] pointer_in;
  // Current head of the FIFO
  logic [LOG_BUFFER_DEPTH-1:0] pointer_out;
  // Wrapped successors of both pointers
  logic [LOG_BUFFER_DEPTH-1:0] pointer_in_next;
  logic [LOG_BUFFER_DEPTH-1:0] pointer_out_next;
  // Read address applied to the RAM, one ahead on a pop
  logic [LOG_BUFFER_DEPTH-1:0] pointer_out_bram;
  // Number of stored records, one bit wider to hold BUFFER_DEPTH
  logic [LOG_BUFFER_DEPTH:0]   elements;

  logic full;
  logic push;
  logic pop;

  assign full = (elements == BUFFER_DEPTH);

  // Write only into a free slot, never while flushing
  assign push = valid_in && !full && !flush_entries;
  // Head leaves when the arbiter takes it
  assign pop  = valid_out && ready_in;

  // Handshake outputs
  assign valid_out = (elements != '0);
  assign ready_out = !full && !flush_entries;

  // Pointer wrap at BUFFER_DEPTH, which need not be a power of two
  assign pointer_in_next  = (pointer_in == LOG_BUFFER_DEPTH'(BUFFER_DEPTH - 1)) ?
                            '0 : pointer_in + 1'b1;
  assign pointer_out_next = (pointer_out == LOG_BUFFER_DEPTH'(BUFFER_DEPTH - 1)) ?
                            '0 : pointer_out + 1'b1;

  // ------------------------------------------------------------------------
  // Fill level, flush wins over any push or pop
  // ------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      elements <= '0;
    end
    else if (flush_entries)
    begin
      elements <= '0;
    end
    else if (push && !pop)
    begin
      elements <= elements + 1'b1;
    end
    else if (pop && !push)
    begin
      elements <= elements - 1'b1;
    end
    // Push and pop together, level unchanged
  end

  // ------------------------------------------------------------------------
  // Pointer update
  // ------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      pointer_in  <= '0;
      pointer_out <= '0;
    end
    else if (flush_entries)
    begin
      pointer_in  <= '0;
      pointer_out <= '0;
    end
    else
    begin
      if (push)
      begin
        pointer_in <= pointer_in_next;
      end
      if (pop)
      begin
        pointer_out <= pointer_out_next;
      end
    end
  end

  // RAM reads one cycle late, so address the next head during a pop
  // to keep the first word falling through
  assign pointer_out_bram = pop ? pointer_out_next : pointer_out;

  rab_ram #(
    .ADDR_WIDTH ( LOG_BUFFER_DEPTH ),
    .DATA_WIDTH ( RAB_MISS_BITS    )
  ) ram_i (
    .clk   ( clk              ),
    .we    ( push             ),
    .waddr ( pointer_in       ),
    .wdata ( data_in          ),
    .raddr ( pointer_out_bram ),
    .rdata ( data_out         )
  );

endmodule

/* hw/rab_miss_arbiter.sv */
`timescale 1ns/100ps

module rab_miss_arbiter
  (
    input  logic                                         clk,
    input  logic                                         rstn,

    // Port buffers
    input  logic               [rab_pkg::RAB_N_PORTS-1:0] buf_valid,
    input  rab_pkg::rab_miss_t [rab_pkg::RAB_N_PORTS-1:0] buf_data,
    output logic               [rab_pkg::RAB_N_PORTS-1:0] buf_ready,

    // Granted record towards the logger
    output logic                                         grant_valid,
    output rab_pkg::rab_miss_t                           grant_miss,
    output logic                                         grant_port,
    input  logic                                         grant_ready
  );

  import rab_pkg::*;

  // Port holding priority this cycle
  rab_arb_prio_e prio_q;

  // Preferred port as an index
  logic pref;
  // Winning port
  logic win;
  // Completed transfer to the logger
  logic xfer;

  assign pref = (prio_q == PRIO_PORT1);

  // ------------------------------------------------------------------------
  // Combinational grant
  // ------------------------------------------------------------------------

  // Priority port wins if valid, otherwise the other one
  always_comb
  begin
    if (buf_valid[pref])
    begin
      win = pref;
    end
    else
    begin
      win = ~pref;
    end
  end

  assign grant_valid = |buf_valid;
  assign grant_miss  = buf_data[win];
  assign grant_port  = win;
  assign xfer        = grant_valid && grant_ready;

  // Ready reaches the winning buffer only
  always_comb
  begin
    buf_ready      = '0;
    buf_ready[win] = grant_ready;
  end

  // ------------------------------------------------------------------------
  // Priority state
  // ------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      prio_q <= PRIO_PORT0;
    end
    else if (xfer)
    begin
      // Hand priority to the port that lost
      prio_q <= win ? PRIO_PORT0 : PRIO_PORT1;
    end
    else if (grant_valid)
    begin
      // Stalled grant keeps its port so the offered record stays put
      prio_q <= win ? PRIO_PORT1 : PRIO_PORT0;
    end
  end

endmodule

/* hw/rab_miss_logger.sv */
`timescale 1ns/100ps

module rab_miss_logger
  #(
    parameter int LOG_DEPTH      = 16,
    parameter int LOG_ADDR_WIDTH = 4
  )
  (
    input  logic                        clk,
    input  logic                        rstn,

    // Granted record from the arbiter
    input  logic                        grant_valid,
    input  rab_pkg::rab_miss_t          grant_miss,
    input  logic                        grant_port,
    output logic                        grant_ready,

    // Host side
    input  logic                        log_clear,
    input  logic [LOG_ADDR_WIDTH-1:0]   rd_addr,
    output rab_pkg::rab_log_entry_t     rd_data,
    output logic [LOG_ADDR_WIDTH:0]     log_count,
    output logic                        log_full
  );

  import rab_pkg::*;

  // Entry assembled from the granted record
  rab_log_entry_t wr_entry;
  // Log write strobe
  logic           log_we;

  // ------------------------------------------------------------------------
  // Flow control
  // ------------------------------------------------------------------------

  assign log_full = (log_count == LOG_DEPTH);

  // Not ready while full
  // A clear cycle also refuses data, since its write would be dropped
  assign grant_ready = !log_full && !log_clear;

  // Write on the handshake edge
  assign log_we = grant_valid && grant_ready;

  // Tag the record with its source port
  always_comb
  begin
    wr_entry.miss = grant_miss;
    wr_entry.port = grant_port;
  end

  // ------------------------------------------------------------------------
  // Entry counter
  // ------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      log_count <= '0;
    end
    else if (log_clear)
    begin
      log_count <= '0;
    end
    else if (log_we)
    begin
      log_count <= log_count + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Log memory
  // ------------------------------------------------------------------------

  // Next free slot is the low part of the count
  // Host read port returns data one cycle after rd_addr
  rab_ram #(
    .ADDR_WIDTH ( LOG_ADDR_WIDTH ),
    .DATA_WIDTH ( RAB_ENTRY_BITS )
  ) log_ram_i (
    .clk   ( clk                            ),
    .we    ( log_we                         ),
    .waddr ( log_count[LOG_ADDR_WIDTH-1:0]  ),
    .wdata ( wr_entry                       ),
    .raddr ( rd_addr                        ),
    .rdata ( rd_data                        )
  );

endmodule

/* hw/rab_miss_log_top.sv */
`timescale 1ns/100ps

module rab_miss_log_top
  #(
    parameter int BUFFER_DEPTH     = 8,
    parameter int LOG_BUFFER_DEPTH = 3,
    parameter int LOG_DEPTH        = 16,
    parameter int LOG_ADDR_WIDTH   = 4
  )
  (
    input  logic                                         clk,
    input  logic                                         rstn,

    // Miss reports from the slave ports
    input  logic               [rab_pkg::RAB_N_PORTS-1:0] miss_valid,
    input  rab_pkg::rab_miss_t [rab_pkg::RAB_N_PORTS-1:0] miss,
    output logic               [rab_pkg::RAB_N_PORTS-1:0] miss_ready,

    // Control
    input  logic                                         flush_entries,
    input  logic                                         log_clear,

    // Host read back
    input  logic               [LOG_ADDR_WIDTH-1:0]       rd_addr,
    output rab_pkg::rab_log_entry_t                      rd_data,
    output logic               [LOG_ADDR_WIDTH:0]         log_count,
    output logic                                         log_full
  );

  import rab_pkg::*;

  // Buffer outputs towards the arbiter
  logic      [RAB_N_PORTS-1:0] buf_valid;
  rab_miss_t [RAB_N_PORTS-1:0] buf_data;
  logic      [RAB_N_PORTS-1:0] buf_ready;

  // Arbiter to logger
  logic      grant_valid;
  rab_miss_t grant_miss;
  logic      grant_port;
  logic      grant_ready;

  // ------------------------------------------------------------------------
  // One FWFT buffer per slave port
  // ------------------------------------------------------------------------
  for (genvar p = 0; p < RAB_N_PORTS; p++)
  begin : gen_port
    axi_buffer_rab_bram #(
      .BUFFER_DEPTH     ( BUFFER_DEPTH     ),
      .LOG_BUFFER_DEPTH ( LOG_BUFFER_DEPTH )
    ) buffer_i (
      .clk           ( clk           ),
      .rstn          ( rstn          ),
      .data_in       ( miss[p]       ),
      .valid_in      ( miss_valid[p] ),
      .ready_out     ( miss_ready[p] ),
      .data_out      ( buf_data[p]   ),
      .valid_out     ( buf_valid[p]  ),
      .ready_in      ( buf_ready[p]  ),
      .flush_entries ( flush_entries )
    );
  end

  // Round-robin share of the log
  rab_miss_arbiter arbiter_i (
    .clk         ( clk         ),
    .rstn        ( rstn        ),
    .buf_valid   ( buf_valid   ),
    .buf_data    ( buf_data    ),
    .buf_ready   ( buf_ready   ),
    .grant_valid ( grant_valid ),
    .grant_miss  ( grant_miss  ),
    .grant_port  ( grant_port  ),
    .grant_ready ( grant_ready )
  );

  // Shared miss log
  rab_miss_logger #(
    .LOG_DEPTH      ( LOG_DEPTH      ),
    .LOG_ADDR_WIDTH ( LOG_ADDR_WIDTH )
  ) logger_i (
    .clk         ( clk         ),
    .rstn        ( rstn        ),
    .grant_valid ( grant_valid ),
    .grant_miss  ( grant_miss  ),
    .grant_port  ( grant_port  ),
    .grant_ready ( grant_ready ),
    .log_clear   ( log_clear   ),
    .rd_addr     ( rd_addr     ),
    .rd_data     ( rd_data     ),
    .log_count   ( log_count   ),
    .log_full    ( log_full    )
  );

endmodule

/* test/tb_rab_miss_log.sv */
`timescale 1ns/100ps

module tb_rab_miss_log;

  import rab_pkg::*;

  // Small buffers and log so that full is reached quickly
  localparam int BUFFER_DEPTH = 4;
  localparam int LOG_DEPTH    = 8;
  localparam int TIMEOUT      = 200;

  logic            clk = 1'b0;
  logic            rstn;
  logic [1:0]      miss_valid;
  rab_miss_t [1:0] miss;
  logic [1:0]      miss_ready;
  logic            flush_entries;
  logic            log_clear;
  logic [2:0]      rd_addr;
  rab_log_entry_t  rd_data;
  logic [3:0]      log_count;
  logic            log_full;

  integer    seed   = 69560;
  int        errors = 0;
  int        cycle  = 0;

  // Reference model, records accepted per port and their accept edge
  rab_miss_t exp_q[2][$];
  int        acc_q[2][$];

  // Read-back pipeline, one stage per cycle of RAM latency
  int        prev_count = 0;
  logic      [1:0] rd_pend = '0;
  int        rd_time[2];

  // Last logged entry, for the alternation rule
  int        last_time = -10;
  logic      last_port = 1'b0;
  logic      fair_chk  = 1'b0;

  always #5 clk = ~clk;

  rab_miss_log_top #(
    .BUFFER_DEPTH     ( BUFFER_DEPTH ),
    .LOG_BUFFER_DEPTH ( 2            ),
    .LOG_DEPTH        ( LOG_DEPTH    ),
    .LOG_ADDR_WIDTH   ( 3            )
  ) dut_i (.*);

  // ------------------------------------------------------------------------
  // Reporting
  // ------------------------------------------------------------------------
  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("FAILED %s expected %h got %h", name, exp, act);
  endtask

  task automatic note_error(input string what);
    errors++;
    $display("Error at cycle %0d: %s", cycle, what);
  endtask

  task automatic timed_out(input string what);
    $display("Timeout while %s", what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // ------------------------------------------------------------------------
  // Protocol properties
  // ------------------------------------------------------------------------
  // Full flag follows the count
  full_flag: assert property (@(posedge clk) disable iff (!rstn)
    log_full == (log_count == LOG_DEPTH))
    else note_error("log_full disagrees with log_count");

  // At most one entry per cycle
  count_step: assert property (@(posedge clk) disable iff (!rstn)
    !log_clear |=> (log_count == $past(log_count) || log_count == $past(log_count) + 1))
    else note_error("log_count moved by more than one entry");

  clear_zero: assert property (@(posedge clk) disable iff (!rstn)
    log_clear |=> log_count == 0)
    else note_error("log_clear did not empty the log");

  // A full log takes nothing more
  full_hold: assert property (@(posedge clk) disable iff (!rstn)
    log_full && !log_clear |=> log_count == LOG_DEPTH)
    else note_error("log_count left LOG_DEPTH while the log was full");

  flush_block: assert property (@(posedge clk) disable iff (!rstn)
    flush_entries |-> miss_ready == 2'b00)
    else note_error("a buffer was ready during flush");

  reset_empty: assert property (@(posedge clk)
    !rstn |=> log_count == 0)
    else note_error("log_count not zero after a reset cycle");

  // ------------------------------------------------------------------------
  // Monitor and reference model
  // ------------------------------------------------------------------------
  task automatic check_entry(input int w);
    logic      p;
    rab_miss_t exp_miss;
    p = rd_data.port;
    if (exp_q[p].size() == 0)
      note_error($sformatf("log entry from port %0d with nothing pending", p));
    else
    begin
      exp_miss = exp_q[p].pop_front();
      void'(acc_q[p].pop_front());
      entry_ok: assert (rd_data.miss == exp_miss)
        else value_error("rd_data.miss", exp_miss, rd_data.miss);
      // Same port twice in a row while the other port held a record
      // since the earlier of the two transfers
      if (fair_chk && p == last_port &&
          acc_q[!p].size() > 0 && acc_q[!p][0] < last_time)
        note_error($sformatf("port %0d logged twice while port %0d waited", p, !p));
    end
    last_time = w;
    last_port = p;
  endtask

  always @(posedge clk)
  begin
    // Entry addressed two edges ago is now on rd_data
    if (rd_pend[1])
      check_entry(rd_time[1]);
    rd_pend[1] = rd_pend[0];
    rd_time[1] = rd_time[0];
    // A rising count marks a new entry at the old count
    rd_pend[0] = rstn && (log_count == prev_count + 1);
    rd_time[0] = cycle;
    if (rd_pend[0])
      rd_addr <= #1 prev_count[2:0];
    prev_count = rstn ? int'(log_count) : 0;
    for (int p = 0; p < 2; p++)
    begin
      if (rstn && miss_valid[p] && miss_ready[p])
      begin
        exp_q[p].push_back(miss[p]);
        acc_q[p].push_back(cycle);
      end
      // Flush drops every buffered record
      if (flush_entries)
      begin
        exp_q[p].delete();
        acc_q[p].delete();
      end
    end
    cycle++;
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  function automatic rab_miss_t rand_miss();
    rab_miss_t m;
    m.addr   = $random(seed);
    m.id     = $random(seed);
    m.access = rab_access_e'($random(seed) & 1);
    return m;
  endfunction

  // Called 1 ns after an edge, returns 1 ns after the handshake edge
  task automatic send_miss(input int p, input rab_miss_t rec);
    int t;
    miss_valid[p] = 1'b1;
    miss[p]       = rec;
    t = 0;
    @(posedge clk);
    while (!miss_ready[p])
    begin
      t++;
      if (t > TIMEOUT)
        timed_out($sformatf("port %0d waited for miss_ready", p));
      @(posedge clk);
    end
    #1;
    miss_valid[p] = 1'b0;
  endtask

  task automatic stream(input int p, input int n);
    for (int i = 0; i < n; i++)
      send_miss(p, rand_miss());
  endtask

  task automatic wait_count(input int target);
    int t;
    t = 0;
    while (log_count != target)
    begin
      t++;
      if (t > TIMEOUT)
        timed_out($sformatf("waiting for log_count %0d", target));
      @(posedge clk);
      #1;
    end
  endtask

  // Every accepted record logged and read back
  task automatic wait_drained();
    int t;
    t = 0;
    while (rd_pend != '0 || exp_q[0].size() != 0 || exp_q[1].size() != 0)
    begin
      t++;
      if (t > TIMEOUT)
        timed_out("waiting for buffered records to reach the log");
      @(posedge clk);
      #1;
    end
  endtask

  task automatic pulse_clear();
    log_clear = 1'b1;
    @(posedge clk);
    #1;
    log_clear = 1'b0;
  endtask

  task automatic check_idle();
    idle_count: assert (log_count === 4'd0) else value_error("log_count", 0, log_count);
    idle_full: assert (log_full === 1'b0) else value_error("log_full", 0, log_full);
    idle_ready: assert (miss_ready === 2'b11) else value_error("miss_ready", 3, miss_ready);
  endtask

  initial
  begin
    rstn          = 1'b0;
    miss_valid    = '0;
    miss          = '0;
    flush_entries = 1'b0;
    log_clear     = 1'b0;
    rd_addr       = '0;

    // Reset held for four cycles
    repeat (4)
    begin
      @(posedge clk);
      #1;
      check_idle();
    end
    rstn = 1'b1;
    @(posedge clk);
    #1;
    check_idle();

    // Single miss lands at index 0 from port 0
    send_miss(0, rand_miss());
    wait_count(1);
    wait_drained();

    // Both ports busy, the log fills at LOG_DEPTH, then drains after clear
    fair_chk = 1'b1;
    fork
      stream(0, 6);
      stream(1, 6);
    join
    wait_count(LOG_DEPTH);
    pulse_clear();
    wait_drained();
    fair_chk = 1'b0;

    // Back-pressure, full log then a full port 0 buffer
    stream(0, 3);
    wait_count(LOG_DEPTH);
    stream(0, BUFFER_DEPTH);
    bp_ready: assert (miss_ready[0] == 1'b0) else value_error("miss_ready[0]", 0, miss_ready[0]);
    bp_count: assert (log_count == LOG_DEPTH)
      else value_error("log_count", LOG_DEPTH, log_count);
    pulse_clear();
    wait_drained();

    // Flush buffered records behind a full log
    stream(1, 4);
    wait_count(LOG_DEPTH);
    wait_drained();
    fork
      stream(0, 2);
      stream(1, 2);
    join
    flush_entries = 1'b1;
    @(posedge clk);
    #1;
    flush_entries = 1'b0;
    pulse_clear();
    repeat (8)
    begin
      @(posedge clk);
      #1;
      check_idle();
    end
    send_miss(1, rand_miss());
    wait_count(1);
    wait_drained();

    $display("Checks done, %0d errors", errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* files.f */
hw/rab_pkg.sv
hw/rab_ram.sv
hw/axi_buffer_rab_bram.sv
hw/rab_miss_arbiter.sv
hw/rab_miss_logger.sv
hw/rab_miss_log_top.sv
test/tb_rab_miss_log.sv
